// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module execCoreTb \
		--Mdir obj_dir -o simv
	out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

// File: dv/execChecker.sv
// Watches execCore ports only; expects results strictly in instruction order and reserved opcodes never sent
`include "regfile_defines.svh"

module execChecker
  import execPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   instValid,
  input  instrT  instr,
  input  logic   resultValid,
  input  resultT result,
  input  logic   testEnd,
  input  int     testNum,
  output int     errorCount,
  output int     testsFailed,
  output int     sentCount,
  output int     resultCount,
  output int     pendingCount
);

  // Falling edges from the strobe to its result, decode stage plus execute stage
  localparam int RESULT_LATENCY = 2;

  logic [`REG_DATA_W-1:0] shadow [`REG_COUNT]; // Architectural state as the model sees it
  instrT sentQ [$];
  int sentCycleQ [$]; // Cycle each queued instruction was strobed
  instrT popped;
  resultT expected;
  int cycle;
  int sentAt;
  int testSent;
  int testResults;
  int testErrors;

  // Expected write-back for one instruction against the shadow registers
  function automatic resultT expectedResult(instrT ins);
    resultT exp;
    logic [`REG_DATA_W-1:0] a;
    logic [`REG_DATA_W-1:0] b;
    a = shadow[ins.rs1];
    b = shadow[ins.rs2];
    exp.rd = ins.rd;
    case (ins.opcode)
      LDI:     exp.value = {8'h00, ins.rs1, ins.rs2}; // Zero-extended immediate
      ADD:     exp.value = a + b;
      SUB:     exp.value = a - b;
      AND:     exp.value = a & b;
      OR:      exp.value = a | b;
      XOR:     exp.value = a ^ b;
      SHL:     exp.value = a << b[3:0];
      SHR:     exp.value = a >> b[3:0];
      DSADD:   exp.value = shadow[`REG_DS] + b; // rs1 plays no part
      GETSP:   exp.value = shadow[`REG_SP];
      default: exp.value = '0;
    endcase
    return exp;
  endfunction

  function automatic string testName(int num);
    case (num)
      1:       return "reset and load";
      2:       return "alu operations";
      3:       return "special registers";
      4:       return "back to back";
      5:       return "random stream";
      default: return "unknown";
    endcase
  endfunction

  // Sampled at the falling edge, where ports and strobes are settled
  always @(negedge clk) begin
    cycle++;
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        shadow[i] = '0;
      end
      sentQ.delete();
      sentCycleQ.delete();
      pendingCount = 0;
    end else begin
      if (resultValid) begin
        if (sentQ.size() == 0) begin
          $display("ERROR at time %0t: result reported with no instruction outstanding", $time);
          errorCount++;
          testErrors++;
        end else begin
          popped   = sentQ.pop_front();
          sentAt   = sentCycleQ.pop_front();
          expected = expectedResult(popped);
          if (cycle - sentAt != RESULT_LATENCY) begin
            $display("FAILED at time %0t: resultValid latency got %0d expected %0d",
                     $time, cycle - sentAt, RESULT_LATENCY);
            errorCount++;
            testErrors++;
          end
          if (result.rd !== expected.rd) begin
            $display("FAILED at time %0t: result.rd got %0d expected %0d",
                     $time, result.rd, expected.rd);
            errorCount++;
            testErrors++;
          end
          if (result.value !== expected.value) begin
            $display("FAILED at time %0t: result.value got 16'h%04h expected 16'h%04h",
                     $time, result.value, expected.value);
            errorCount++;
            testErrors++;
          end
          shadow[expected.rd] = expected.value; // Model state moves on regardless of DUT
          resultCount++;
          testResults++;
        end
      end
      if (instValid) begin
        sentQ.push_back(instr);
        sentCycleQ.push_back(cycle);
        sentCount++;
        testSent++;
      end
      pendingCount = sentQ.size();
      if (testEnd) begin
        if (testResults != testSent) begin
          $display("test %0d: %0d instructions were sent but %0d results came back",
                   testNum, testSent, testResults);
        end
        if (testErrors != 0 || testResults != testSent) begin
          testsFailed++;
        end
        $display("test %0d %s: %0d instructions, %0d results, %0d mismatches, %s",
                 testNum, testName(testNum), testSent, testResults, testErrors,
                 (testErrors == 0 && testResults == testSent) ? "ok" : "failed");
        testSent    = 0;
        testResults = 0;
        testErrors  = 0;
      end
    end
  end

endmodule

// File: dv/execCoreTb.sv
// Inputs change 1 time unit after each rising edge; run length is bounded by a fixed cycle limit
`include "regfile_defines.svh"

module execCoreTb
  import execPkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int STREAM_LEN   = 300;
  localparam int MAX_GAP      = 3;
  // Instruction slots per test, the random stream weighted by its longest gap
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 48 + 12 + 7 * 8 * 11 + 6 * 17 + 16
                              + STREAM_LEN * (MAX_GAP + 1) + 64;

  logic   clk = 1'b0;
  logic   reset;
  logic   instValid;
  instrT  instr;
  logic   resultValid;
  resultT result;
  logic   testEnd;
  int     testNum;
  int     errorCount;
  int     testsFailed;
  int     sentCount;
  int     resultCount;
  int     pendingCount;
  int     cycleCount;
  logic [31:0] lfsrState = 32'h74f1b7d6;

  always #50 clk = ~clk;

  execCore i_dut (
    .clk         (clk),
    .reset       (reset),
    .instValid   (instValid),
    .instr       (instr),
    .resultValid (resultValid),
    .result      (result)
  );

  execChecker i_checker (
    .clk          (clk),
    .reset        (reset),
    .instValid    (instValid),
    .instr        (instr),
    .resultValid  (resultValid),
    .result       (result),
    .testEnd      (testEnd),
    .testNum      (testNum),
    .errorCount   (errorCount),
    .testsFailed  (testsFailed),
    .sentCount    (sentCount),
    .resultCount  (resultCount),
    .pendingCount (pendingCount)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] randBits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v         = {v[14:0], lfsrState[31]};
      lfsrState = lfsrNext(lfsrState);
    end
    return v;
  endfunction

  function automatic logic [3:0] randGp(); // Registers 0 to 12, 13 is the scratch register
    return 4'(randBits(4) % 13);
  endfunction

  function automatic instrT makeInstr(opcodeT op, logic [3:0] rd, logic [3:0] rs1,
                                      logic [3:0] rs2);
    instrT ins;
    ins.opcode = op;
    ins.rd     = rd;
    ins.rs1    = rs1;
    ins.rs2    = rs2;
    return ins;
  endfunction

  // Called just after a rising edge, returns just after a rising edge
  task automatic sendInstr(instrT ins, int gap);
    instValid = 1'b1;
    instr     = ins;
    @(posedge clk);
    #1;
    instValid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Full 16-bit value in five instructions; r must not be 13
  task automatic loadWide(logic [3:0] r, logic [15:0] v);
    sendInstr(makeInstr(LDI, r, v[15:12], v[11:8]), 0);
    sendInstr(makeInstr(LDI, 4'd13, 4'd0, 4'd8), 0);
    sendInstr(makeInstr(SHL, r, r, 4'd13), 0);
    sendInstr(makeInstr(LDI, 4'd13, v[7:4], v[3:0]), 0);
    sendInstr(makeInstr(OR, r, r, 4'd13), 0);
  endtask

  task automatic endTest(int num);
    while (pendingCount != 0) begin
      @(posedge clk);
      #1;
    end
    testNum = num;
    testEnd = 1'b1;
    @(posedge clk);
    #1;
    testEnd = 1'b0;
  endtask

  initial begin
    cycleCount = 0;
    while (cycleCount < CYCLE_LIMIT) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [15:0] v;
    logic [3:0]  a;
    logic [3:0]  b;
    opcodeT      op;
    reset     = 1'b1;
    instValid = 1'b0;
    instr     = '0;
    testEnd   = 1'b0;
    testNum   = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    // Every register reads zero, then takes and returns an immediate
    for (int r = 0; r < `REG_COUNT; r++) begin
      sendInstr(makeInstr(ADD, 4'(r), 4'(r), 4'd0), 0);
    end
    for (int r = 0; r < `REG_COUNT; r++) begin
      v = randBits(8);
      sendInstr(makeInstr(LDI, 4'(r), v[7:4], v[3:0]), 0);
    end
    for (int r = 0; r < `REG_COUNT; r++) begin
      sendInstr(makeInstr(OR, 4'(r), 4'(r), 4'(r)), 0); // OR with itself reads back
    end
    endTest(1);

    loadWide(4'd1, 16'hfff0); // Forces carry out of ADD and borrow on SUB
    loadWide(4'd2, 16'h0025);
    sendInstr(makeInstr(ADD, 4'd3, 4'd1, 4'd2), 0);
    sendInstr(makeInstr(SUB, 4'd4, 4'd2, 4'd1), 0);
    for (int k = 1; k <= 7; k++) begin // ADD through SHR
      op = opcodeT'(k);
      repeat (8) begin
        a = randGp();
        b = randGp();
        loadWide(a, randBits(16));
        loadWide(b, randBits(16));
        sendInstr(makeInstr(op, randGp(), a, b), 0);
      end
    end
    endTest(2);

    repeat (6) begin
      loadWide(4'd14, randBits(16));
      loadWide(4'd15, randBits(16));
      a = randGp();
      loadWide(a, randBits(16)); // rs1 junk that DSADD must ignore
      sendInstr(makeInstr(DSADD, randGp(), a, randGp()), 0);
      sendInstr(makeInstr(GETSP, randGp(), randGp(), randGp()), 0);
    end
    endTest(3);

    // Each instruction reads the two destinations before it, no idle cycles
    v = randBits(8);
    sendInstr(makeInstr(LDI, 4'd1, v[7:4], v[3:0]), 0);
    v = randBits(8);
    sendInstr(makeInstr(LDI, 4'd2, v[7:4], v[3:0]), 0);
    for (int i = 3; i < 17; i++) begin
      op = opcodeT'(1 + randBits(3) % 7);
      sendInstr(makeInstr(op, 4'((i - 1) % 12 + 1), 4'((i - 2) % 12 + 1),
                          4'((i - 3) % 12 + 1)), 0);
    end
    endTest(4);

    repeat (STREAM_LEN) begin
      op = opcodeT'(randBits(4) % 10);
      sendInstr(makeInstr(op, 4'(randBits(4)), 4'(randBits(4)), 4'(randBits(4))),
                int'(randBits(2)));
    end
    endTest(5);

    $display("summary: %0d tests, %0d failed, %0d instructions, %0d results, %0d mismatches",
             5, testsFailed, sentCount, resultCount, errorCount);
    if (testsFailed == 0 && errorCount == 0 && sentCount == resultCount) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: hdl/aluUnit.sv
// Wrap-around arithmetic only, no flags; write-back is the value being registered so it lands with the result
`include "regfile_defines.svh"

module aluUnit
  import execPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   decValid,
  input  decodedT                dec,
  input  logic [`REG_DATA_W-1:0] readBus1,
  input  logic [`REG_DATA_W-1:0] readBus2,
  output logic                   resultValid,
  output resultT                 result,
  output logic                   writeValid,
  output logic [`REG_ADDR_W-1:0] writeReg,
  output logic [`REG_DATA_W-1:0] writeData
);

  logic [`REG_DATA_W-1:0] opValue;
  logic [`REG_DATA_W-1:0] immExt;
  logic [`REG_DATA_W-1:0] aluValue;
  resultT                 resultNext;

  assign immExt = {{(`REG_DATA_W - `REG_IMM_W){1'b0}}, dec.imm};

  // DSADD and GETSP are plain adds, the register file supplies the operands
  always_comb begin
    case (dec.op)
      ADD, DSADD, GETSP: opValue = readBus1 + readBus2;
      SUB:               opValue = readBus1 - readBus2;
      AND:               opValue = readBus1 & readBus2;
      OR:                opValue = readBus1 | readBus2;
      XOR:               opValue = readBus1 ^ readBus2;
      SHL:               opValue = readBus1 << readBus2[3:0];
      SHR:               opValue = readBus1 >> readBus2[3:0];
      default:           opValue = '0; // LDI takes the immediate below
    endcase
  end

  assign aluValue = dec.useImm ? immExt : opValue;

  assign resultNext.rd    = dec.rd;
  assign resultNext.value = aluValue;

  // Register file commits at the same edge the result is captured
  assign writeValid = decValid;
  assign writeReg   = resultNext.rd;
  assign writeData  = resultNext.value;

  always_ff @(posedge clk) begin
    if (reset) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= decValid;
    end
  end

  // Payload only loads with a valid operation
  always_ff @(posedge clk) begin
    if (decValid) begin
      result <= resultNext;
    end
  end

endmodule

// File: hdl/execCore.sv
// Two instructions in flight at most; results come out in order two cycles after the instruction is taken
`include "regfile_defines.svh"

module execCore
  import execPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   instValid,
  input  instrT  instr,
  output logic   resultValid,
  output resultT result
);

  logic                   decValid;
  decodedT                dec;
  logic [`REG_DATA_W-1:0] readBus1;
  logic [`REG_DATA_W-1:0] readBus2;

  // Write-back path from the ALU
  logic                   writeValid;
  logic [`REG_ADDR_W-1:0] writeReg;
  logic [`REG_DATA_W-1:0] writeData;

  instrDecode i_decode (
    .clk       (clk),
    .reset     (reset),
    .instValid (instValid),
    .instr     (instr),
    .decValid  (decValid),
    .dec       (dec)
  );

  regFile i_regFile (
    .clk        (clk),
    .reset      (reset),
    .dec        (dec),
    .writeValid (writeValid),
    .writeReg   (writeReg),
    .writeData  (writeData),
    .readBus1   (readBus1),
    .readBus2   (readBus2)
  );

  aluUnit i_alu (
    .clk         (clk),
    .reset       (reset),
    .decValid    (decValid),
    .dec         (dec),
    .readBus1    (readBus1),
    .readBus2    (readBus2),
    .resultValid (resultValid),
    .result      (result),
    .writeValid  (writeValid),
    .writeReg    (writeReg),
    .writeData   (writeData)
  );

endmodule

// File: hdl/execPkg.sv
// Opcodes 10 to 15 are reserved and must never reach the slice with a valid strobe
`include "regfile_defines.svh"

package execPkg;

  // ALU operations, encodings fixed by the instruction set
  typedef enum logic [`REG_OP_W-1:0] {
    LDI   = 4'd0, // rd = zero-extended immediate
    ADD   = 4'd1,
    SUB   = 4'd2,
    AND   = 4'd3,
    OR    = 4'd4,
    XOR   = 4'd5,
    SHL   = 4'd6, // Shift by rs2[3:0]
    SHR   = 4'd7,
    DSADD = 4'd8, // Data segment plus rs2
    GETSP = 4'd9  // Stack pointer plus zero
  } opcodeT;

  // Raw 16-bit instruction word, opcode in the top nibble
  typedef struct packed {
    opcodeT                  opcode;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`REG_ADDR_W-1:0]  rs1; // Upper immediate half for LDI
    logic [`REG_ADDR_W-1:0]  rs2; // Lower immediate half for LDI
  } instrT;

  // Decode stage output, read by the register file and the ALU
  typedef struct packed {
    opcodeT                  op;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`REG_ADDR_W-1:0]  rs1;
    logic [`REG_ADDR_W-1:0]  rs2;
    logic                    dataSel;  // Force data segment onto read port 1
    logic                    stackSel; // Force stack pointer onto port 1, zero on port 2
    logic                    useImm;
    logic [`REG_IMM_W-1:0]   imm;
  } decodedT;

  // Reported result, also the write-back payload
  typedef struct packed {
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`REG_DATA_W-1:0]  value;
  } resultT;

  // Codes above GETSP have no defined operation
  function automatic logic isReserved(logic [`REG_OP_W-1:0] code);
    return code > GETSP;
  endfunction

  // Special register levels follow straight from the opcode
  function automatic logic needsDataSeg(opcodeT op);
    return op == DSADD;
  endfunction

  function automatic logic needsStack(opcodeT op);
    return op == GETSP;
  endfunction

endpackage

// File: hdl/instrDecode.sv
// Accepts one instruction per cycle with no back-pressure; reserved opcodes are illegal on a valid strobe
`include "regfile_defines.svh"

module instrDecode
  import execPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    instValid,
  input  instrT   instr,
  output logic    decValid,
  output decodedT dec
);

  decodedT decNext;

  // Split the word and derive the select levels
  always_comb begin
    decNext          = dec; // Hold between strobes
    if (instValid) begin
      decNext.op       = instr.opcode;
      decNext.rd       = instr.rd;
      decNext.rs1      = instr.rs1;
      decNext.rs2      = instr.rs2;
      decNext.dataSel  = needsDataSeg(instr.opcode);
      decNext.stackSel = needsStack(instr.opcode);
      decNext.useImm   = (instr.opcode == LDI);
      decNext.imm      = {instr.rs1, instr.rs2}; // Immediate shares the source fields
    end
  end

  // Strobe follows the input by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      decValid <= 1'b0;
    end else begin
      decValid <= instValid;
    end
  end

  // Decoded fields drive the register file selects, so they start cleared
  always_ff @(posedge clk) begin
    if (reset) begin
      dec <= '0;
    end else begin
      dec <= decNext;
    end
  end

  // Source must keep reserved codes off the bus
  noReservedOpcode : assert property (
    @(posedge clk) disable iff (reset)
    instValid |-> !isReserved(instr.opcode)
  ) else $error("instrDecode: reserved opcode %0d with instValid", instr.opcode);

endmodule

// File: hdl/regFile.sv
// Reads are combinational from the decoded instruction; a write is visible to reads only after the clock edge
`include "regfile_defines.svh"

module regFile
  import execPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  decodedT                dec,
  input  logic                   writeValid,
  input  logic [`REG_ADDR_W-1:0] writeReg,
  input  logic [`REG_DATA_W-1:0] writeData,
  output logic [`REG_DATA_W-1:0] readBus1,
  output logic [`REG_DATA_W-1:0] readBus2
);

  // Register storage, per-register enables replace separate flop modules
  logic [`REG_DATA_W-1:0] regs [`REG_COUNT];

  // One-hot write select, all zero without a write
  logic [`REG_COUNT-1:0] writeSel;

  logic [`REG_DATA_W-1:0] dataSeg;
  logic [`REG_DATA_W-1:0] stackPtr;

  assign dataSeg  = regs[`REG_DS];
  assign stackPtr = regs[`REG_SP];

  // Write number to enable vector
  always_comb begin
    writeSel = '0;
    if (writeValid) begin
      writeSel[writeReg] = 1'b1;
    end
  end

  // Every register clears on reset so early reads are defined
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        if (writeSel[i]) begin
          regs[i] <= writeData;
        end
      end
    end
  end

  // Port 1 priority: stack pointer, then data segment, then rs1
  always_comb begin
    if (dec.stackSel) begin
      readBus1 = stackPtr;
    end else if (dec.dataSel) begin
      readBus1 = dataSeg;
    end else begin
      readBus1 = regs[dec.rs1];
    end
  end

  // Port 2 is zeroed for GETSP so the ALU adds nothing to the stack pointer
  always_comb begin
    if (dec.stackSel) begin
      readBus2 = '0;
    end else begin
      readBus2 = regs[dec.rs2];
    end
  end

  // At most one register takes the write-back data
  writeSelOneHot : assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(writeSel)
  ) else $error("regFile: write select %b is not one-hot", writeSel);

  // Decode never asks for both special registers at once
  specialSelExclusive : assert property (
    @(posedge clk) disable iff (reset)
    !(dec.dataSel && dec.stackSel)
  ) else $error("regFile: dataSel and stackSel both set");

endmodule

// File: include/regfile_defines.svh
// Sizes assume a 16-bit datapath with sixteen registers; changing one width alone breaks the instruction layout
`ifndef REGFILE_DEFINES_SVH
`define REGFILE_DEFINES_SVH

// Datapath and register width
`define REG_DATA_W 16

// Number of architectural registers, 0 to 13 general purpose
`define REG_COUNT 16

// Register number width, must cover REG_COUNT
`define REG_ADDR_W 4

// Special registers, still reachable by number
`define REG_DS 14 // Data segment
`define REG_SP 15 // Stack pointer

// Instruction fields
`define REG_OP_W 4 // Opcode field
`define REG_IMM_W 8 // LDI immediate, spans the rs1 and rs2 fields

`endif

// File: verilog.f
+incdir+include
hdl/execPkg.sv
hdl/regFile.sv
hdl/instrDecode.sv
hdl/aluUnit.sv
hdl/execCore.sv
dv/execChecker.sv
dv/execCoreTb.sv
